// File: Makefile
TOP = sysctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sysctrl.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sysctrl.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Finished with errors" sim.log || \
		! grep -q "Finished with no errors" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: src/sysctrl.sv
`timescale 1ns/1ns

module sysctrl #(
    parameter int no_mems    = 2,
    parameter int no_periphs = 8,
    parameter int no_cores   = 2
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  sysctrl_pkg::apb_req_t                   apb_req,
    output sysctrl_pkg::apb_rsp_t                   apb_rsp,
    input  sysctrl_pkg::addr_t                      rst_boot_addr,
    output sysctrl_pkg::tgt_ctrl_t [no_mems-1:0]    mem_ctrl,
    output sysctrl_pkg::tgt_ctrl_t [no_periphs-1:0] periph_ctrl,
    output sysctrl_pkg::tgt_ctrl_t [no_cores-1:0]   core_ctrl,
    input  logic [no_mems-1:0]                      mem_pause_ack,
    input  logic [no_periphs-1:0]                   periph_pause_ack,
    input  logic [no_cores-1:0]                     core_pause_ack,
    input  logic [no_periphs-1:0]                   periph_irq,
    output sysctrl_pkg::addr_t [no_cores-1:0]       core_boot_addr,
    output logic [no_cores-1:0]                     core_irq
);
    import sysctrl_pkg::*;

    localparam int n_tgt = no_mems + no_periphs + no_cores;

    tgt_ctrl_t       [n_tgt-1:0]    ctrl;
    tgt_status_t     [n_tgt-1:0]    status;
    maestro_action_e [n_tgt-1:0]    pending;
    logic            [n_tgt-1:0]    busy;
    logic            [n_tgt-1:0]    start;
    logic            [n_tgt-1:0]    pause_ack;
    maestro_action_e                action;
    logic            [no_cores-1:0] bar_we;
    logic            [no_cores-1:0] ier_we;
    data_t                          wdata;
    data_t           [no_cores-1:0] core_ier;

    // flat target order is mems, periphs, cores
    assign pause_ack = {core_pause_ack, periph_pause_ack, mem_pause_ack};
    assign {core_ctrl, periph_ctrl, mem_ctrl} = ctrl;

    sysctrl_apb_slave #(
        .no_mems    (no_mems),
        .no_periphs (no_periphs),
        .no_cores   (no_cores)
    ) apb_slave (
        .clk            (clk),
        .rst_n          (rst_n),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .tgt_status     (status),
        .tgt_busy       (busy),
        .pending_action (pending),
        .start          (start),
        .action         (action),
        .bar_we         (bar_we),
        .ier_we         (ier_we),
        .wdata          (wdata),
        .core_bar       (core_boot_addr),
        .core_ier       (core_ier)
    );

    // first target of each group comes out of reset running
    for (genvar i = 0; i < n_tgt; i++) begin : g_maestro
        sysctrl_maestro #(
            .run_at_reset (i == 0 || i == no_mems || i == no_mems + no_periphs)
        ) maestro (
            .clk       (clk),
            .rst_n     (rst_n),
            .start     (start[i]),
            .action    (action),
            .pause_ack (pause_ack[i]),
            .ctrl      (ctrl[i]),
            .status    (status[i]),
            .busy      (busy[i]),
            .pending   (pending[i])
        );
    end

    sysctrl_core_regs #(
        .no_periphs (no_periphs),
        .no_cores   (no_cores)
    ) core_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .rst_boot_addr (rst_boot_addr),
        .bar_we        (bar_we),
        .ier_we        (ier_we),
        .wdata         (wdata),
        .periph_irq    (periph_irq),
        .core_bar      (core_boot_addr),
        .core_ier      (core_ier),
        .core_irq      (core_irq)
    );

endmodule

// File: src/sysctrl_apb_slave.sv
`timescale 1ns/1ns

module sysctrl_apb_slave #(
    parameter int no_mems    = 2,
    parameter int no_periphs = 8,
    parameter int no_cores   = 2,
    localparam int n_tgt     = no_mems + no_periphs + no_cores
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  sysctrl_pkg::apb_req_t                    apb_req,
    output sysctrl_pkg::apb_rsp_t                    apb_rsp,
    input  sysctrl_pkg::tgt_status_t [n_tgt-1:0]     tgt_status,
    input  logic [n_tgt-1:0]                         tgt_busy,
    input  sysctrl_pkg::maestro_action_e [n_tgt-1:0] pending_action,
    output logic [n_tgt-1:0]                         start,
    output sysctrl_pkg::maestro_action_e             action,
    output logic [no_cores-1:0]                      bar_we,
    output logic [no_cores-1:0]                      ier_we,
    output sysctrl_pkg::data_t                       wdata,
    input  sysctrl_pkg::addr_t [no_cores-1:0]        core_bar,
    input  sysctrl_pkg::data_t [no_cores-1:0]        core_ier
);
    import sysctrl_pkg::*;

    localparam int tgt_w      = $clog2(n_tgt);
    localparam int core_first = no_mems + no_periphs;

    typedef struct packed {
        logic             hit;
        logic [tgt_w-1:0] tgt;
        logic [2:0]       ofs;
    } decode_t;

    decode_t dec_d;
    decode_t dec_q;
    logic    access;
    logic    err;
    data_t   rdata;

    // targets are numbered mems first, then periphs, then cores
    function automatic logic [29:0] tgt_base(input int i);
        if (i < no_mems) return 30'(mem_base + i * tgt_stride);
        if (i < core_first) return 30'(periph_base + (i - no_mems) * tgt_stride);
        return 30'(core_base + (i - core_first) * core_stride);
    endfunction

    function automatic logic [29:0] tgt_span(input int i);
        return (i >= core_first) ? 30'(core_stride) : 30'(tgt_stride);
    endfunction

    always_comb begin
        logic [29:0] word;
        word  = apb_req.paddr[31:2];
        dec_d = '0;
        for (int i = 0; i < n_tgt; i++) begin
            if (word >= tgt_base(i) && word < tgt_base(i) + tgt_span(i)) begin
                dec_d.hit = 1'b1;
                dec_d.tgt = tgt_w'(i);
                dec_d.ofs = 3'(word - tgt_base(i));
            end
        end
    end

    // decode is captured in the setup cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_q <= '0;
        end else if (apb_req.psel && !apb_req.penable) begin
            dec_q <= dec_d;
        end
    end

    assign access = apb_req.psel && apb_req.penable;

    always_comb begin
        rdata  = '0;
        err    = 1'b0;
        start  = '0;
        bar_we = '0;
        ier_we = '0;
        if (!dec_q.hit) begin
            err = 1'b1;
        end else begin
            case (dec_q.ofs)
                3'(reg_status): begin
                    rdata = {30'd0, tgt_status[dec_q.tgt]};
                    err   = apb_req.pwrite;
                end
                3'(reg_action): begin
                    if (tgt_busy[dec_q.tgt]) begin
                        rdata = {30'd0, pending_action[dec_q.tgt]};
                    end
                    if (apb_req.pwrite) begin
                        err              = tgt_busy[dec_q.tgt];
                        start[dec_q.tgt] = access && !tgt_busy[dec_q.tgt];
                    end
                end
                3'(reg_bar): begin
                    for (int c = 0; c < no_cores; c++) begin
                        if (int'(dec_q.tgt) == core_first + c) begin
                            rdata     = core_bar[c];
                            bar_we[c] = access && apb_req.pwrite;
                        end
                    end
                end
                3'(reg_ier): begin
                    for (int c = 0; c < no_cores; c++) begin
                        if (int'(dec_q.tgt) == core_first + c) begin
                            rdata     = core_ier[c];
                            ier_we[c] = access && apb_req.pwrite;
                        end
                    end
                end
                default: err = 1'b1;
            endcase
        end
    end

    // no wait states
    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && err;

    assign action = maestro_action_e'(apb_req.pwdata[1:0]);
    assign wdata  = apb_req.pwdata;

endmodule

// File: src/sysctrl_core_regs.sv
`timescale 1ns/1ns

module sysctrl_core_regs #(
    parameter int no_periphs = 8,
    parameter int no_cores   = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  sysctrl_pkg::addr_t                rst_boot_addr,
    input  logic [no_cores-1:0]               bar_we,
    input  logic [no_cores-1:0]               ier_we,
    input  sysctrl_pkg::data_t                wdata,
    input  logic [no_periphs-1:0]             periph_irq,
    output sysctrl_pkg::addr_t [no_cores-1:0] core_bar,
    output sysctrl_pkg::data_t [no_cores-1:0] core_ier,
    output logic [no_cores-1:0]               core_irq
);
    import sysctrl_pkg::*;

    data_t [no_cores-1:0] ier_next;

    // irq follows the new enable on the same edge
    always_comb begin
        for (int c = 0; c < no_cores; c++) begin
            ier_next[c] = ier_we[c] ? wdata : core_ier[c];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_bar <= {no_cores{rst_boot_addr}};
            core_ier <= '0;
            core_irq <= '0;
        end else begin
            for (int c = 0; c < no_cores; c++) begin
                if (bar_we[c]) begin
                    core_bar[c] <= wdata;
                end
                core_ier[c] <= ier_next[c];
                core_irq[c] <= |(periph_irq & ier_next[c][no_periphs-1:0]);
            end
        end
    end

endmodule

// File: src/sysctrl_maestro.sv
`timescale 1ns/1ns

module sysctrl_maestro #(
    parameter bit run_at_reset = 1'b0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  sysctrl_pkg::maestro_action_e action,
    input  logic                         pause_ack,
    output sysctrl_pkg::tgt_ctrl_t       ctrl,
    output sysctrl_pkg::tgt_status_t     status,
    output logic                         busy,
    output sysctrl_pkg::maestro_action_e pending
);
    import sysctrl_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_resume,
        st_pause,
        st_stop
    } state_e;

    state_e          state;
    tgt_ctrl_t       ctrl_q;
    tgt_status_t     status_q;
    maestro_action_e pending_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= st_idle;
            pending_q         <= act_none;
            ctrl_q.srst       <= !run_at_reset;
            ctrl_q.pause_req  <= 1'b0;
            status_q.stopped  <= !run_at_reset;
            status_q.paused   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        pending_q <= action;
                        case (action)
                            act_resume: begin
                                ctrl_q <= '0;
                                state  <= st_resume;
                            end
                            act_pause: begin
                                ctrl_q.pause_req <= 1'b1;
                                state            <= st_pause;
                            end
                            act_stop: begin
                                ctrl_q.pause_req <= 1'b1;
                                state            <= st_stop;
                            end
                            default: state <= st_idle;
                        endcase
                    end
                end
                // target leaves pause once ack drops
                st_resume: begin
                    if (!pause_ack) begin
                        status_q <= '0;
                        state    <= st_idle;
                    end
                end
                st_pause: begin
                    if (pause_ack) begin
                        status_q.paused <= 1'b1;
                        state           <= st_idle;
                    end
                end
                // reset only once the target is quiet
                st_stop: begin
                    if (pause_ack) begin
                        ctrl_q.srst <= 1'b1;
                        status_q    <= '1;
                        state       <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign ctrl    = ctrl_q;
    assign status  = status_q;
    assign busy    = (state != st_idle);
    assign pending = pending_q;

endmodule

// File: src/sysctrl_pkg.sv
package sysctrl_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // master to slave
    typedef struct packed {
        addr_t      paddr;
        logic       psel;
        logic       penable;
        logic       pwrite;
        data_t      pwdata;
        logic [3:0] pstrb;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    // lines to one target
    typedef struct packed {
        logic srst;
        logic pause_req;
    } tgt_ctrl_t;

    typedef struct packed {
        logic stopped;
        logic paused;
    } tgt_status_t;

    typedef enum logic [1:0] {
        act_none   = 2'd0,
        act_resume = 2'd1,
        act_pause  = 2'd2,
        act_stop   = 2'd3
    } maestro_action_e;

    // word indices, byte address is index << 2
    localparam int mem_base    = 'h100;
    localparam int periph_base = 'h200;
    localparam int core_base   = 'h400;

    localparam int tgt_stride  = 3;
    localparam int core_stride = 5;

    localparam int reg_status = 0;
    localparam int reg_action = 2;
    localparam int reg_bar    = 3;
    localparam int reg_ier    = 4;

endpackage

// File: sysctrl.f
src/sysctrl_pkg.sv
src/sysctrl_apb_slave.sv
src/sysctrl_maestro.sv
src/sysctrl_core_regs.sv
src/sysctrl.sv
verif/sysctrl_assert.sv
verif/sysctrl_tb.sv

// File: verif/sysctrl_assert.sv
`timescale 1ns/1ns

module sysctrl_assert #(
    parameter int n_tgt = 12
) (
    input logic                               clk,
    input logic                               rst_n,
    input sysctrl_pkg::apb_req_t              apb_req,
    input sysctrl_pkg::apb_rsp_t              apb_rsp,
    input sysctrl_pkg::tgt_ctrl_t [n_tgt-1:0] ctrl,
    input logic [n_tgt-1:0]                   pause_ack
);
    logic access;

    assign access = apb_req.psel && apb_req.penable;

    // no wait states
    assert property (@(posedge clk) disable iff (!rst_n) access |-> apb_rsp.pready)
        else $error("pready low in an access cycle");

    assert property (@(posedge clk) disable iff (!rst_n) apb_rsp.pslverr |-> access)
        else $error("pslverr outside an access cycle");

    // target must be quiet before it goes into reset
    for (genvar i = 0; i < n_tgt; i++) begin : g_tgt
        assert property (@(posedge clk) disable iff (!rst_n)
                         $rose(ctrl[i].srst) |-> pause_ack[i])
            else $error("srst rose on target %0d while pause_ack was low", i);
    end

endmodule

bind sysctrl sysctrl_assert #(
    .n_tgt (no_mems + no_periphs + no_cores)
) assert0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .ctrl      (ctrl),
    .pause_ack (pause_ack)
);

// File: verif/sysctrl_input.txt
// op addr wdata expect (hex); op 0 read, 1 write (expect pslverr), 2 ctrl of target addr
// op 3 action sequence, 4 action while busy, 5 boot_addr port of core addr, 6 irq of core addr
0 00000400 00000000 00000000
0 0000040c 00000000 00000002
0 00000808 00000000 00000000
0 00001014 00000000 00000002
2 00000000 00000000 00000000
2 00000001 00000000 00000002
3 00000408 00007900 00331100
3 00000414 00007901 00331100
3 00000808 00007902 00331100
3 00000814 00007903 00331100
3 00000820 00007904 00331100
3 0000082c 00007905 00331100
3 00000838 00007906 00331100
3 00000844 00007907 00331100
3 00000850 00007908 00331100
3 0000085c 00007909 00331100
3 00001008 0000790a 00331100
3 0000101c 0000790b 00331100
4 00000408 00000200 00000011
5 00000000 00000000 deadbeef
1 0000100c deadc0de 00000000
0 0000100c 00000000 deadc0de
5 00000000 00000000 deadc0de
6 00000000 00000000 00000000
1 00001010 ffffffff 00000000
6 00000000 00000000 00000001
0 00001010 00000000 ffffffff
1 00000404 00000000 00000001
1 00000400 00000000 00000001

// File: verif/sysctrl_tb.sv
`timescale 1ns/1ns

module sysctrl_tb;
    import sysctrl_pkg::*;

    localparam int no_mems         = 2;
    localparam int no_periphs      = 8;
    localparam int no_cores        = 2;
    localparam int n_tgt           = no_mems + no_periphs + no_cores;
    localparam int tgt_w           = $clog2(n_tgt);
    localparam int core_w          = $clog2(no_cores);
    localparam int half_period     = 50;
    localparam int max_steps       = 64;
    localparam int cycles_per_step = 200;

    logic                       clk = 1'b0;
    logic                       rst_n;
    apb_req_t                   apb_req;
    apb_rsp_t                   apb_rsp;
    addr_t                      rst_boot_addr;
    tgt_ctrl_t [no_mems-1:0]    mem_ctrl;
    tgt_ctrl_t [no_periphs-1:0] periph_ctrl;
    tgt_ctrl_t [no_cores-1:0]   core_ctrl;
    logic [n_tgt-1:0]           pause_ack = '0;
    logic [no_periphs-1:0]      periph_irq;
    addr_t [no_cores-1:0]       core_boot_addr;
    logic [no_cores-1:0]        core_irq;

    tgt_ctrl_t [n_tgt-1:0] ctrl_all;
    logic                  ack_hold;
    int                    ack_wait [n_tgt] = '{default: -1};
    integer                seed = 80;
    logic [31:0]           step_mem [0:4*max_steps-1];
    int                    n_steps;
    int                    error_count = 0;
    int                    pass_count = 0;
    int                    fail_count = 0;
    int                    cycle_count = 0;
    int                    cycle_limit = 0;

    sysctrl #(
        .no_mems    (no_mems),
        .no_periphs (no_periphs),
        .no_cores   (no_cores)
    ) dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .apb_req          (apb_req),
        .apb_rsp          (apb_rsp),
        .rst_boot_addr    (rst_boot_addr),
        .mem_ctrl         (mem_ctrl),
        .periph_ctrl      (periph_ctrl),
        .core_ctrl        (core_ctrl),
        .mem_pause_ack    (pause_ack[no_mems-1:0]),
        .periph_pause_ack (pause_ack[no_mems+no_periphs-1:no_mems]),
        .core_pause_ack   (pause_ack[n_tgt-1:no_mems+no_periphs]),
        .periph_irq       (periph_irq),
        .core_boot_addr   (core_boot_addr),
        .core_irq         (core_irq)
    );

    assign ctrl_all = {core_ctrl, periph_ctrl, mem_ctrl};

    always #half_period clk = ~clk;

    // ack follows pause_req after 0 to 7 cycles unless ack_hold is set
    always @(negedge clk) begin
        for (int t = 0; t < n_tgt; t++) begin
            if (!ack_hold && pause_ack[t] != ctrl_all[t].pause_req) begin
                if (ack_wait[t] < 0) begin
                    ack_wait[t] = $unsigned($random(seed)) % 8;
                end
                if (ack_wait[t] == 0) begin
                    pause_ack[t] <= ctrl_all[t].pause_req;
                    ack_wait[t] = -1;
                end else begin
                    ack_wait[t] = ack_wait[t] - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout, the tests did not finish within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_status(input string name, input tgt_status_t got,
                                input tgt_status_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_ctrl(input string name, input tgt_ctrl_t got, input tgt_ctrl_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // setup, access, then back to idle
    task automatic bus_transfer(input logic write, input addr_t addr, input data_t wdata,
                                output data_t rdata, output logic err);
        @(negedge clk);
        apb_req.paddr   = addr;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.pstrb   = '1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(half_period / 2);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic wait_idle(input addr_t action_addr);
        data_t rdata;
        logic  err;
        rdata = '1;
        while (rdata != '0) begin
            bus_transfer(1'b0, action_addr, '0, rdata, err);
        end
    endtask

    task automatic read_back(input logic [tgt_w-1:0] tgt, input addr_t action_addr,
                             input logic [7:0] exp_byte);
        data_t rdata;
        logic  err;
        // status sits two words below the action register
        bus_transfer(1'b0, action_addr - 32'd8, '0, rdata, err);
        check_status("status", tgt_status_t'(rdata[1:0]), tgt_status_t'(exp_byte[1:0]));
        check_ctrl("ctrl", ctrl_all[tgt], tgt_ctrl_t'(exp_byte[5:4]));
    endtask

    // target in codes[7:0] and four actions from bit 8 up
    // one result byte per action
    task automatic run_actions(input addr_t action_addr, input data_t codes,
                               input data_t results);
        logic [tgt_w-1:0] tgt;
        maestro_action_e  act;
        data_t            rdata;
        logic             err;
        tgt = codes[tgt_w-1:0];
        for (int k = 0; k < 4; k++) begin
            act = maestro_action_e'(codes[9:8]);
            bus_transfer(1'b1, action_addr, {30'd0, act}, rdata, err);
            check_err("pslverr", err, 1'b0);
            wait_idle(action_addr);
            read_back(tgt, action_addr, results[7:0]);
            codes   = codes >> 2;
            results = results >> 8;
        end
    endtask

    task automatic run_busy_write(input addr_t action_addr, input data_t codes,
                                  input data_t results);
        logic [tgt_w-1:0] tgt;
        maestro_action_e  act;
        data_t            rdata;
        logic             err;
        tgt = codes[tgt_w-1:0];
        act = maestro_action_e'(codes[9:8]);
        ack_hold = 1'b1;
        bus_transfer(1'b1, action_addr, {30'd0, act}, rdata, err);
        check_err("pslverr", err, 1'b0);
        bus_transfer(1'b1, action_addr, {30'd0, act}, rdata, err);
        check_err("pslverr", err, 1'b1);
        bus_transfer(1'b0, action_addr, '0, rdata, err);
        check_data("prdata", rdata, {30'd0, act});
        ack_hold = 1'b0;
        wait_idle(action_addr);
        read_back(tgt, action_addr, results[7:0]);
    endtask

    initial begin
        data_t op;
        data_t addr;
        data_t wdata;
        data_t expv;
        data_t rdata;
        logic  err;
        int    errors_before;

        apb_req       = '0;
        rst_n         = 1'b0;
        rst_boot_addr = 32'hdeadbeef;
        periph_irq    = '0;
        periph_irq[1] = 1'b1;
        ack_hold      = 1'b0;

        // top nibble f marks words the file did not fill
        for (int i = 0; i < 4 * max_steps; i++) begin
            step_mem[i] = 32'hf000_0000 | 32'(i);
        end
        $readmemh("verif/sysctrl_input.txt", step_mem);
        n_steps = 0;
        while (n_steps < max_steps && step_mem[4*n_steps][31:28] != 4'hf) begin
            n_steps++;
        end
        if (n_steps == 0) begin
            $display("no test steps could be read from the input file");
            error_count++;
        end
        cycle_limit = n_steps * cycles_per_step;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int s = 0; s < n_steps; s++) begin
            op            = step_mem[4*s];
            addr          = step_mem[4*s+1];
            wdata         = step_mem[4*s+2];
            expv          = step_mem[4*s+3];
            errors_before = error_count;
            case (op)
                32'd0: begin
                    bus_transfer(1'b0, addr, '0, rdata, err);
                    check_data("prdata", rdata, expv);
                end
                32'd1: begin
                    bus_transfer(1'b1, addr, wdata, rdata, err);
                    check_err("pslverr", err, expv[0]);
                end
                32'd2: check_ctrl("ctrl", ctrl_all[addr[tgt_w-1:0]], tgt_ctrl_t'(expv[1:0]));
                32'd3: run_actions(addr, wdata, expv);
                32'd4: run_busy_write(addr, wdata, expv);
                32'd5: check_data("core_boot_addr", core_boot_addr[addr[core_w-1:0]], expv);
                32'd6: check_err("core_irq", core_irq[addr[core_w-1:0]], expv[0]);
                default: begin
                    $display("step %0d has an unknown operation code %h", s, op);
                    error_count++;
                end
            endcase
            if (error_count == errors_before) begin
                pass_count++;
                $display("step %0d op %0h addr %h: pass", s, op, addr);
            end else begin
                fail_count++;
                $display("step %0d op %0h addr %h: FAIL", s, op, addr);
            end
        end

        $display("steps passed: %0d, steps failed: %0d", pass_count, fail_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
